// ==== bench/ft_alu_tb.sv ====
// testbench for the fault-tolerant alu stage
// seeded random requests, configs and lane masks checked against a reference model

`timescale 1ns/1ps
`include "ft_alu_defs.svh"

module ft_alu_tb;

	import alu_pkg::*;
	import ft_pkg::*;

	// valid and error flags of one item
	typedef struct packed {
		logic valid;
		logic det;
		logic cor;
	} flags_t;

	// expected outputs of one driven cycle
	typedef struct packed {
		flags_t                flags;
		alu_res_t              res;
		logic [`NUM_LANES-1:0] lane_err;
	} exp_t;

	localparam int CNT_MAX    = (1 << `ERR_CNT_WIDTH) - 1;
	// about 1900 cycles of stimulus and resets, half again as margin
	localparam int MAX_CYCLES = 3000;

	logic                  clk;
	logic                  rst_i;
	logic                  valid_i;
	alu_req_t              req_i;
	redund_cfg_t           cfg_i;
	fault_mask_t           fault_mask_i;
	logic                  valid_o;
	alu_res_t              res_o;
	logic                  err_detected_o;
	logic                  err_corrected_o;
	logic [`NUM_LANES-1:0] permanent_faulty_o;

	integer                seed = 23;
	exp_t                  exp_q[$];
	fault_mask_t           mask_prev;
	int                    err_cnt [`NUM_LANES];
	logic [`NUM_LANES-1:0] perm_model;
	int                    cycles;

	ft_alu_top u_ft_alu_top (
		.clk                (clk),
		.rst_i              (rst_i),
		.valid_i            (valid_i),
		.req_i              (req_i),
		.cfg_i              (cfg_i),
		.fault_mask_i       (fault_mask_i),
		.valid_o            (valid_o),
		.res_o              (res_o),
		.err_detected_o     (err_detected_o),
		.err_corrected_o    (err_corrected_o),
		.permanent_faulty_o (permanent_faulty_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// random helpers
	////////////////////////////////////////////////////////////
	function automatic int rand_below(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [`ALU_WIDTH-1:0] rand_word();
		return $random(seed);
	endfunction

	// no spare, or the spare on exactly one slot
	function automatic logic [2:0] rand_spare();
		int r;
		r = rand_below(4);
		return (r == 3) ? 3'b000 : 3'(1 << r);
	endfunction

	function automatic alu_req_t rand_req();
		alu_req_t r;
		r.op = alu_op_e'(4'(rand_below(10)));
		r.a  = rand_word();
		r.b  = rand_word();
		// equal operands now and then so cmp toggles
		if (rand_below(4) == 0) begin
			r.b = r.a;
		end
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////
	function automatic alu_res_t lane_result(alu_req_t req, logic [`ALU_WIDTH-1:0] mask);
		alu_res_t              r;
		logic [`ALU_WIDTH-1:0] w;
		int                    sh;
		sh = int'(req.b % `ALU_WIDTH);
		case (req.op)
			ALU_ADD:  w = req.a + req.b;
			ALU_SUB:  w = req.a - req.b;
			ALU_AND:  w = req.a & req.b;
			ALU_OR:   w = req.a | req.b;
			ALU_XOR:  w = req.a ^ req.b;
			ALU_SLL:  w = req.a << sh;
			ALU_SRL:  w = req.a >> sh;
			ALU_SRA:  w = $signed(req.a) >>> sh;
			ALU_SLT:  w = ($signed(req.a) < $signed(req.b)) ? 1 : 0;
			ALU_SLTU: w = (req.a < req.b) ? 1 : 0;
			default:  w = '0;
		endcase
		// injected fault flips result bits, cmp untouched
		r.result = w ^ mask;
		r.cmp    = (req.a == req.b);
		return r;
	endfunction

	function automatic exp_t predict_item(logic valid, alu_req_t req, redund_cfg_t cfg,
		fault_mask_t mask);
		exp_t       e;
		alu_res_t   slot [3];
		lane_idx_t  lidx [3];
		logic [2:0] flag;
		logic [1:0] bsel;
		e = '0;
		flag = 3'b000;
		// slot k on lane k or the spare
		for (int k = 0; k < 3; k++) begin
			lidx[k] = cfg.spare_sel[k] ? lane_idx_t'(`NUM_LANES - 1) : lane_idx_t'(k);
		end
		if (cfg.only_two) begin
			for (int k = 0; k < 2; k++) begin
				if (cfg.pair_sel[k]) begin
					lidx[k] = lidx[2];
				end
			end
		end
		for (int k = 0; k < 3; k++) begin
			slot[k] = lane_result(req, mask[lidx[k]]);
		end
		e.res = slot[0];
		if (cfg.only_two) begin
			// two lanes left, detect only
			if (slot[0] != slot[1]) begin
				flag = 3'b011;
			end
		end else if (slot[0] == slot[1] && slot[0] == slot[2]) begin
			flag = 3'b000;
		end else if (slot[0] == slot[1]) begin
			flag = 3'b100;
		end else if (slot[0] == slot[2]) begin
			flag = 3'b010;
		end else if (slot[1] == slot[2]) begin
			e.res = slot[1];
			flag  = 3'b001;
		end else begin
			flag = 3'b111;
		end
		e.flags.det = (flag != 3'b000);
		e.flags.cor = !cfg.only_two && (flag != 3'b000) && (flag != 3'b111);
		if (cfg.bypass != 2'd0) begin
			bsel  = cfg.bypass - 2'd1;
			e.res = slot[bsel];
		end
		for (int k = 0; k < 3; k++) begin
			if (flag[k]) begin
				e.lane_err[lidx[k]] = 1'b1;
			end
		end
		e.flags.valid = valid;
		if (!valid) begin
			e.flags    = '0;
			e.lane_err = '0;
		end
		return e;
	endfunction

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////
	task automatic report_mismatch(string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		$display("Some tests failed");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic compare_res(alu_res_t got, alu_res_t exp);
		if (got !== exp) begin
			report_mismatch($sformatf("res_o got %h expected %h", got, exp));
		end
	endtask

	task automatic compare_flags(flags_t got, flags_t exp);
		if (got !== exp) begin
			report_mismatch($sformatf("valid/detected/corrected got %b expected %b", got, exp));
		end
	endtask

	task automatic compare_perm(logic [`NUM_LANES-1:0] got, logic [`NUM_LANES-1:0] exp);
		if (got !== exp) begin
			report_mismatch($sformatf("permanent_faulty_o got %b expected %b", got, exp));
		end
	endtask

	////////////////////////////////////////////////////////////
	// drive and check, one call per clock
	////////////////////////////////////////////////////////////
	// item driven two edges ago is on the outputs now
	task automatic check_stage_outputs();
		exp_t e;
		if (exp_q.size() == 2) begin
			e = exp_q.pop_front();
			compare_flags({valid_o, err_detected_o, err_corrected_o}, e.flags);
			if (e.flags.valid) begin
				compare_res(res_o, e.res);
			end
			// tracker lags the flags by one edge
			compare_perm(permanent_faulty_o, perm_model);
			for (int l = 0; l < `NUM_LANES; l++) begin
				if (e.lane_err[l] && err_cnt[l] < CNT_MAX) begin
					err_cnt[l]++;
				end
				if (err_cnt[l] >= `PERM_FAULT_THRESHOLD) begin
					perm_model[l] = 1'b1;
				end
			end
		end
	endtask

	// masks act one cycle after the request, so they trail by one call
	task automatic drive_cycle(logic valid, alu_req_t req, redund_cfg_t cfg, fault_mask_t mask);
		@(posedge clk);
		#1;
		check_stage_outputs();
		valid_i      = valid;
		req_i        = req;
		cfg_i        = cfg;
		fault_mask_i = mask_prev;
		mask_prev    = mask;
		exp_q.push_back(predict_item(valid, req, cfg, mask));
	endtask

	task automatic reset_dut();
		@(posedge clk);
		#1;
		rst_i   = 1'b1;
		valid_i = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rst_i        = 1'b0;
		fault_mask_i = '0;
		mask_prev    = '0;
		perm_model   = '0;
		exp_q.delete();
		for (int l = 0; l < `NUM_LANES; l++) begin
			err_cnt[l] = 0;
		end
		compare_flags({valid_o, err_detected_o, err_corrected_o}, '0);
		compare_perm(permanent_faulty_o, '0);
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////
	initial begin
		redund_cfg_t cfg;
		fault_mask_t mask;
		lane_idx_t   lane;
		rst_i        = 1'b1;
		valid_i      = 1'b0;
		req_i        = '0;
		cfg_i        = '0;
		fault_mask_i = '0;
		mask_prev    = '0;
		reset_dut();
		// clean lanes, default config, some idle cycles
		repeat (400) drive_cycle(rand_below(8) != 0, rand_req(), '0, '0);
		// one faulty lane behind a random slot
		repeat (300) begin
			cfg           = '0;
			cfg.spare_sel = rand_spare();
			lane          = lane_idx_t'(rand_below(3));
			if (cfg.spare_sel[lane]) begin
				lane = lane_idx_t'(`NUM_LANES - 1);
			end
			mask       = '0;
			mask[lane] = rand_word() | `ALU_WIDTH'(1);
			drive_cycle(1'b1, rand_req(), cfg, mask);
		end
		// every lane corrupted differently, no majority
		repeat (300) begin
			cfg           = '0;
			cfg.spare_sel = rand_spare();
			for (int l = 0; l < `NUM_LANES; l++) begin
				mask[l] = rand_word() | `ALU_WIDTH'(1);
			end
			drive_cycle(1'b1, rand_req(), cfg, mask);
		end
		// two-lane mode, fault on a used or an idle lane
		repeat (300) begin
			cfg           = '0;
			cfg.only_two  = 1'b1;
			cfg.pair_sel  = 2'(rand_below(4));
			cfg.spare_sel = 3'(rand_below(8));
			mask          = '0;
			mask[lane_idx_t'(rand_below(`NUM_LANES))] = rand_word() | `ALU_WIDTH'(1);
			drive_cycle(1'b1, rand_req(), cfg, mask);
		end
		// raw slot bypass, half the items with a faulty lane
		repeat (300) begin
			cfg           = '0;
			cfg.bypass    = 2'(rand_below(4));
			cfg.spare_sel = rand_spare();
			mask          = '0;
			if (rand_below(2) == 0) begin
				mask[lane_idx_t'(rand_below(`NUM_LANES))] = rand_word() | `ALU_WIDTH'(1);
			end
			drive_cycle(1'b1, rand_req(), cfg, mask);
		end
		// flush, then retire one lane from a clean count
		repeat (2) drive_cycle(1'b0, '0, '0, '0);
		reset_dut();
		lane       = lane_idx_t'(rand_below(3));
		mask       = '0;
		mask[lane] = rand_word() | `ALU_WIDTH'(1);
		repeat (250) drive_cycle(rand_below(2) == 0, rand_req(), '0, mask);
		repeat (2) drive_cycle(1'b0, '0, '0, '0);
		// only the faulted lane is retired by now
		compare_perm(permanent_faulty_o, `NUM_LANES'(1) << lane);
		$display("All tests passed");
		$finish;
	end

	// watchdog
	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("run did not finish within %0d cycles", MAX_CYCLES);
		$display("Some tests failed");
		$fatal(1, "timeout");
	end

endmodule

// ==== files.f ====
+incdir+hdl
hdl/alu_pkg.sv
hdl/ft_pkg.sv
hdl/lane_dispatch.sv
hdl/alu_lane.sv
hdl/tmr_voter.sv
hdl/fault_tracker.sv
hdl/ft_alu_top.sv
bench/ft_alu_tb.sv

// ==== hdl/alu_lane.sv ====
// single alu replica
// integer ops plus equality, with a fault-injection xor on the result

`timescale 1ns/1ps
`include "ft_alu_defs.svh"

module alu_lane (
	input  alu_pkg::alu_req_t       req_i,
	input  logic [`ALU_WIDTH-1:0]   fault_mask_i,
	output alu_pkg::alu_res_t       res_o
);

	import alu_pkg::*;

	localparam int SHAMT_W = $clog2(`ALU_WIDTH);

	logic [SHAMT_W-1:0]    shamt;
	logic [`ALU_WIDTH-1:0] raw;

	// shift amount from the low bits of b
	assign shamt = req_i.b[SHAMT_W-1:0];

	////////////////////////////////////////////////////////////
	// operation select
	////////////////////////////////////////////////////////////
	always_comb begin
		case (req_i.op)
			ALU_ADD:  raw = req_i.a + req_i.b;
			ALU_SUB:  raw = req_i.a - req_i.b;
			ALU_AND:  raw = req_i.a & req_i.b;
			ALU_OR:   raw = req_i.a | req_i.b;
			ALU_XOR:  raw = req_i.a ^ req_i.b;
			ALU_SLL:  raw = req_i.a << shamt;
			ALU_SRL:  raw = req_i.a >> shamt;
			// arithmetic shift keeps the sign bit
			ALU_SRA:  raw = $signed(req_i.a) >>> shamt;
			// set-less-than, zero extended flag
			ALU_SLT:  raw = `ALU_WIDTH'($signed(req_i.a) < $signed(req_i.b));
			ALU_SLTU: raw = `ALU_WIDTH'(req_i.a < req_i.b);
			default:  raw = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// fault injection and output
	////////////////////////////////////////////////////////////
	// mask of zero leaves the replica fault free
	assign res_o.result = raw ^ fault_mask_i;

	// equality bit for every op, not masked
	assign res_o.cmp = (req_i.a == req_i.b);

endmodule

// ==== hdl/alu_pkg.sv ====
// alu arithmetic types
// operation encoding, request and result words of one replica

`include "ft_alu_defs.svh"

package alu_pkg;

	// operation select, 4 bit encoding
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLL  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_SLT  = 4'd8,
		ALU_SLTU = 4'd9
	} alu_op_e;

	// one request, shared by all replicas
	typedef struct packed {
		alu_op_e               op;
		logic [`ALU_WIDTH-1:0] a;
		logic [`ALU_WIDTH-1:0] b;
	} alu_req_t;

	// replica output, result word plus a==b
	typedef struct packed {
		logic [`ALU_WIDTH-1:0] result;
		logic                  cmp;
	} alu_res_t;

endpackage

// ==== hdl/fault_tracker.sv ====
// permanent fault tracker
// per-lane saturating error counters with sticky retire flags

`timescale 1ns/1ps
`include "ft_alu_defs.svh"

module fault_tracker (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic                  valid_i,
	input  logic [`NUM_LANES-1:0] lane_err_i,
	output logic [`NUM_LANES-1:0] permanent_faulty_o
);

	localparam logic [`ERR_CNT_WIDTH-1:0] THRESH = `ERR_CNT_WIDTH'(`PERM_FAULT_THRESHOLD);

	logic [`NUM_LANES-1:0][`ERR_CNT_WIDTH-1:0] err_cnt;
	logic [`NUM_LANES-1:0][`ERR_CNT_WIDTH-1:0] cnt_next;

	////////////////////////////////////////////////////////////
	// next count
	////////////////////////////////////////////////////////////
	always_comb begin
		for (int l = 0; l < `NUM_LANES; l++) begin
			cnt_next[l] = err_cnt[l];
			// saturate at all ones
			if (valid_i && lane_err_i[l] && (err_cnt[l] != '1)) begin
				cnt_next[l] = err_cnt[l] + `ERR_CNT_WIDTH'(1);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// counters and sticky flags
	////////////////////////////////////////////////////////////
	// flag rises on the same edge the count hits the threshold
	always_ff @(posedge clk) begin
		if (rst_i) begin
			err_cnt            <= '0;
			permanent_faulty_o <= '0;
		end else begin
			err_cnt <= cnt_next;
			for (int l = 0; l < `NUM_LANES; l++) begin
				if (cnt_next[l] >= THRESH) begin
					permanent_faulty_o[l] <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== hdl/ft_alu_defs.svh ====
// fault-tolerant alu stage parameters
// widths, replica count and permanent-fault threshold

`ifndef FT_ALU_DEFS_SVH
`define FT_ALU_DEFS_SVH

// data path width of every replica
`define ALU_WIDTH 32

// physical replicas, three voted plus one spare
`define NUM_LANES 4

// per-lane error counter width
`define ERR_CNT_WIDTH 8

// flagged items after which a lane is retired
`define PERM_FAULT_THRESHOLD 4

`endif

// ==== hdl/ft_alu_top.sv ====
// fault-tolerant alu stage
// dispatcher, four alu replicas, voter and fault tracker
// two cycle latency, one request per cycle

`timescale 1ns/1ps
`include "ft_alu_defs.svh"

module ft_alu_top (
	input  logic                   clk,
	input  logic                   rst_i,
	input  logic                   valid_i,
	input  alu_pkg::alu_req_t      req_i,
	input  ft_pkg::redund_cfg_t    cfg_i,
	input  ft_pkg::fault_mask_t    fault_mask_i,
	output logic                   valid_o,
	output alu_pkg::alu_res_t      res_o,
	output logic                   err_detected_o,
	output logic                   err_corrected_o,
	output logic [`NUM_LANES-1:0]  permanent_faulty_o
);

	import alu_pkg::*;
	import ft_pkg::*;

	alu_req_t [`NUM_LANES-1:0] req_q;
	alu_res_t [`NUM_LANES-1:0] lane_res;
	slot_map_t                 map_q;
	logic                      valid_q;
	logic [`NUM_LANES-1:0]     lane_err;

	////////////////////////////////////////////////////////////
	// dispatch stage
	////////////////////////////////////////////////////////////
	lane_dispatch u_lane_dispatch (
		.clk     (clk),
		.rst_i   (rst_i),
		.valid_i (valid_i),
		.req_i   (req_i),
		.cfg_i   (cfg_i),
		.valid_o (valid_q),
		.req_o   (req_q),
		.map_o   (map_q)
	);

	// replicas, each with its own injection mask
	for (genvar k = 0; k < `NUM_LANES; k++) begin : g_lane
		alu_lane u_alu_lane (
			.req_i        (req_q[k]),
			.fault_mask_i (fault_mask_i[k]),
			.res_o        (lane_res[k])
		);
	end

	////////////////////////////////////////////////////////////
	// vote and track
	////////////////////////////////////////////////////////////
	tmr_voter u_tmr_voter (
		.clk             (clk),
		.rst_i           (rst_i),
		.valid_i         (valid_q),
		.lane_res_i      (lane_res),
		.map_i           (map_q),
		.valid_o         (valid_o),
		.res_o           (res_o),
		.err_detected_o  (err_detected_o),
		.err_corrected_o (err_corrected_o),
		.lane_err_o      (lane_err)
	);

	fault_tracker u_fault_tracker (
		.clk                (clk),
		.rst_i              (rst_i),
		.valid_i            (valid_o),
		.lane_err_i         (lane_err),
		.permanent_faulty_o (permanent_faulty_o)
	);

endmodule

// ==== hdl/ft_pkg.sv ====
// redundancy management types
// configuration word, decoded slot map and fault-injection masks

`include "ft_alu_defs.svh"

package ft_pkg;

	// physical lane number
	typedef logic [$clog2(`NUM_LANES)-1:0] lane_idx_t;

	// software-visible redundancy configuration
	typedef struct packed {
		// bit k: slot k takes the spare lane
		logic [2:0] spare_sel;
		logic       only_two;
		// bit k: slot k takes slot 2's source, only_two mode
		logic [1:0] pair_sel;
		// 0 voted result, 1..3 raw slot 0..2
		logic [1:0] bypass;
	} redund_cfg_t;

	// decoded form, travels with each item
	typedef struct packed {
		lane_idx_t [2:0]       lane_idx;
		logic [`NUM_LANES-1:0] lane_en;
		logic                  only_two;
		logic [1:0]            bypass;
	} slot_map_t;

	// one xor mask per lane on the result word
	typedef logic [`NUM_LANES-1:0][`ALU_WIDTH-1:0] fault_mask_t;

endpackage

// ==== hdl/lane_dispatch.sv ====
// request dispatcher
// decodes the redundancy config into a slot map and loads only
// the lane operand registers that feed an active slot

`timescale 1ns/1ps
`include "ft_alu_defs.svh"

module lane_dispatch (
	input  logic                                   clk,
	input  logic                                   rst_i,
	input  logic                                   valid_i,
	input  alu_pkg::alu_req_t                      req_i,
	input  ft_pkg::redund_cfg_t                    cfg_i,
	output logic                                   valid_o,
	output alu_pkg::alu_req_t [`NUM_LANES-1:0]     req_o,
	output ft_pkg::slot_map_t                      map_o
);

	import ft_pkg::*;

	slot_map_t map_d;

	////////////////////////////////////////////////////////////
	// config decode
	////////////////////////////////////////////////////////////
	always_comb begin
		map_d = '0;
		// spare select, slot k takes lane k or the spare
		for (int k = 0; k < 3; k++) begin
			if (cfg_i.spare_sel[k]) begin
				map_d.lane_idx[k] = lane_idx_t'(`NUM_LANES - 1);
			end else begin
				map_d.lane_idx[k] = lane_idx_t'(k);
			end
		end
		// two lanes left, slots 0/1 may reuse slot 2's source
		if (cfg_i.only_two) begin
			for (int k = 0; k < 2; k++) begin
				if (cfg_i.pair_sel[k]) begin
					map_d.lane_idx[k] = map_d.lane_idx[2];
				end
			end
		end
		// any lane named by a slot gets its operands
		for (int k = 0; k < 3; k++) begin
			map_d.lane_en[map_d.lane_idx[k]] = 1'b1;
		end
		map_d.only_two = cfg_i.only_two;
		map_d.bypass   = cfg_i.bypass;
	end

	////////////////////////////////////////////////////////////
	// lane operand registers
	////////////////////////////////////////////////////////////
	// idle lanes keep their old operands so their logic stays quiet
	always_ff @(posedge clk) begin
		for (int l = 0; l < `NUM_LANES; l++) begin
			if (valid_i && map_d.lane_en[l]) begin
				req_o[l] <= req_i;
			end
		end
	end

	// valid and map follow the item into the vote stage
	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_o <= 1'b0;
			map_o   <= '0;
		end else begin
			valid_o <= valid_i;
			map_o   <= map_d;
		end
	end

endmodule

// ==== hdl/tmr_voter.sv ====
// triple-modular voter
// spare and pair steering, majority vote, bypass and per-lane
// error attribution, all outputs registered

`timescale 1ns/1ps
`include "ft_alu_defs.svh"

module tmr_voter (
	input  logic                                clk,
	input  logic                                rst_i,
	input  logic                                valid_i,
	input  alu_pkg::alu_res_t [`NUM_LANES-1:0]  lane_res_i,
	input  ft_pkg::slot_map_t                   map_i,
	output logic                                valid_o,
	output alu_pkg::alu_res_t                   res_o,
	output logic                                err_detected_o,
	output logic                                err_corrected_o,
	output logic [`NUM_LANES-1:0]               lane_err_o
);

	import alu_pkg::*;

	alu_res_t [2:0]        slot;
	alu_res_t              voted;
	alu_res_t              res_d;
	logic                  eq01;
	logic                  eq02;
	logic                  eq12;
	logic                  det;
	logic                  cor;
	logic [2:0]            slot_err;
	logic [`NUM_LANES-1:0] lane_err_d;

	////////////////////////////////////////////////////////////
	// lane to slot steering
	////////////////////////////////////////////////////////////
	// spare and pair muxes already folded into the map
	always_comb begin
		for (int k = 0; k < 3; k++) begin
			slot[k] = lane_res_i[map_i.lane_idx[k]];
		end
	end

	// whole word compare, result and cmp together
	assign eq01 = (slot[0] == slot[1]);
	assign eq02 = (slot[0] == slot[2]);
	assign eq12 = (slot[1] == slot[2]);

	////////////////////////////////////////////////////////////
	// vote
	////////////////////////////////////////////////////////////
	always_comb begin
		voted    = slot[0];
		det      = 1'b0;
		cor      = 1'b0;
		slot_err = 3'b000;
		if (map_i.only_two) begin
			// dmr mode, detect only
			det      = !eq01;
			slot_err = {1'b0, !eq01, !eq01};
		end else if (eq01 && eq02) begin
			// unanimous
			slot_err = 3'b000;
		end else if (eq01) begin
			// slot 2 is the odd one
			det      = 1'b1;
			cor      = 1'b1;
			slot_err = 3'b100;
		end else if (eq02) begin
			det      = 1'b1;
			cor      = 1'b1;
			slot_err = 3'b010;
		end else if (eq12) begin
			// slot 0 outvoted
			voted    = slot[1];
			det      = 1'b1;
			cor      = 1'b1;
			slot_err = 3'b001;
		end else begin
			// no majority, pass slot 0 and blame everyone
			det      = 1'b1;
			slot_err = 3'b111;
		end
	end

	// bypass picks a raw slot, flags still from the vote
	assign res_d = (map_i.bypass == 2'd0) ? voted : slot[map_i.bypass - 2'd1];

	// flagged slot back to its physical lane
	always_comb begin
		lane_err_d = '0;
		for (int k = 0; k < 3; k++) begin
			if (slot_err[k]) begin
				lane_err_d[map_i.lane_idx[k]] = 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// output registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (valid_i) begin
			res_o <= res_d;
		end
	end

	// flags only ever high alongside valid_o
	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_o         <= 1'b0;
			err_detected_o  <= 1'b0;
			err_corrected_o <= 1'b0;
			lane_err_o      <= '0;
		end else begin
			valid_o         <= valid_i;
			err_detected_o  <= valid_i & det;
			err_corrected_o <= valid_i & cor;
			lane_err_o      <= valid_i ? lane_err_d : '0;
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the ft_alu testbench with Verilator
cd "$(dirname "$0")" \
	&& verilator --binary -j 0 --top-module ft_alu_tb -f files.f -o sim_ft_alu \
	&& ./obj_dir/sim_ft_alu \
	|| exit 1
